// ==== hdl/ctrl_defs.svh ====
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH
`default_nettype none

// ~~~~~~~~~~~~~~~ field widths ~~~~~~~~~~~~~~~
`define CTRL_OPCODE_W   6
`define CTRL_IORD_W     2
`define CTRL_PCSRC_W    2
`define CTRL_SRCB_W     2
`define CTRL_REGDST_W   2
`define CTRL_STORE_W    2
`define CTRL_MEMTOREG_W 3

// ~~~~~~~~~~~~~~~ mux select codes ~~~~~~~~~~~~~~~
`define PC_SRC_ALU    2'b00
`define PC_SRC_BRANCH 2'b01
`define PC_SRC_JUMP   2'b10
`define PC_SRC_EPC    2'b11

`define WB_ALUOUT 3'b000
`define WB_SLT    3'b100 // zero extended lt flag.
`define WB_SHIFT  3'b101

`define REG_DST_RT 2'b00
`define REG_DST_RA 2'b01
`define REG_DST_SP 2'b10
`define REG_DST_RD 2'b11

`define STORE_WORD 2'b01
`define STORE_HALF 2'b10
`define STORE_BYTE 2'b11

`define SRCB_B          2'b00
`define SRCB_FOUR       2'b01
`define SRCB_IMM        2'b10
`define SRCB_BRANCH_OFS 2'b11 // sign extended imm shifted left by two.

`default_nettype wire
`endif

// ==== hdl/ctrl_pkg.sv ====
`include "ctrl_defs.svh"
`default_nettype none

package ctrl_pkg;

	// ~~~~~~~~~~~~~~~ fsm states ~~~~~~~~~~~~~~~
	typedef enum logic [6:0] {
		ST_FETCH_1           = 7'd1,
		ST_FETCH_2           = 7'd2,
		ST_FETCH_3           = 7'd3,
		ST_DECODE_1          = 7'd4,
		ST_DECODE_2          = 7'd5,
		ST_ADD               = 7'd6,
		ST_SUB               = 7'd7,
		ST_AND               = 7'd8,
		ST_ARITH_WB          = 7'd9,
		ST_SHIFT_SHAMT       = 7'd10,
		ST_SHIFT_LEFT        = 7'd11,
		ST_SHIFT_RIGHT_ARITH = 7'd12,
		ST_SHIFT_RIGHT_LOG   = 7'd13,
		ST_SHIFT_REG         = 7'd14,
		ST_SHIFT_WB          = 7'd15,
		ST_SLT               = 7'd16,
		ST_ADD_IMM           = 7'd17,
		ST_ADD_IMM_WB        = 7'd18,
		ST_BRANCH_EQ_1       = 7'd20,
		ST_BRANCH_EQ_2       = 7'd21,
		ST_BRANCH_CMP_1      = 7'd22,
		ST_BRANCH_CMP_2      = 7'd23,
		ST_STORE_1           = 7'd24,
		ST_STORE_2           = 7'd25,
		ST_STORE_3           = 7'd26,
		ST_SW                = 7'd27,
		ST_SH                = 7'd28,
		ST_SB                = 7'd29,
		ST_BREAK             = 7'd30,
		ST_JR                = 7'd31,
		ST_RTE               = 7'd32,
		ST_J                 = 7'd33,
		ST_JAL_1             = 7'd34,
		ST_JAL_2             = 7'd35,
		ST_JAL_3             = 7'd36,
		ST_CLOSE             = 7'd64
	} ctrl_state_e;

	// ~~~~~~~~~~~~~~~ instruction encodings ~~~~~~~~~~~~~~~
	typedef enum logic [`CTRL_OPCODE_W-1:0] {
		OP_RTYPE = 6'b000000,
		OP_J     = 6'b000010,
		OP_JAL   = 6'b000011,
		OP_BEQ   = 6'b000100,
		OP_BNE   = 6'b000101,
		OP_BLE   = 6'b000110,
		OP_BGT   = 6'b000111,
		OP_ADDI  = 6'b001000,
		OP_ADDIU = 6'b001001,
		OP_SB    = 6'b101000,
		OP_SH    = 6'b101001,
		OP_SW    = 6'b101011
	} opcode_e;

	typedef enum logic [`CTRL_OPCODE_W-1:0] {
		FN_SLL   = 6'b000000,
		FN_SRL   = 6'b000010,
		FN_SRA   = 6'b000011,
		FN_SLLV  = 6'b000100,
		FN_SRAV  = 6'b000111,
		FN_JR    = 6'b001000,
		FN_BREAK = 6'b001101,
		FN_RTE   = 6'b010011,
		FN_ADD   = 6'b100000,
		FN_SUB   = 6'b100010,
		FN_AND   = 6'b100100,
		FN_SLT   = 6'b101010
	} funct_e;

	// ~~~~~~~~~~~~~~~ datapath operations ~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		ALU_LOAD = 3'b000, // pass a through.
		ALU_ADD  = 3'b001,
		ALU_SUB  = 3'b010,
		ALU_AND  = 3'b011,
		ALU_CMP  = 3'b111
	} alu_op_e;

	typedef enum logic [2:0] {
		SHIFT_NONE        = 3'b000,
		SHIFT_LOAD        = 3'b001,
		SHIFT_LEFT        = 3'b010,
		SHIFT_RIGHT_LOG   = 3'b011,
		SHIFT_RIGHT_ARITH = 3'b100
	} shift_op_e;

	typedef enum logic [3:0] {
		CLS_ARITH,
		CLS_SHIFT_IMM,
		CLS_SHIFT_REG,
		CLS_SLT,
		CLS_ADD_IMM,
		CLS_BRANCH_EQ,
		CLS_BRANCH_CMP,
		CLS_STORE,
		CLS_BREAK,
		CLS_JR,
		CLS_RTE,
		CLS_JUMP,
		CLS_JAL,
		CLS_UNKNOWN
	} instr_class_e;

endpackage

`default_nettype wire

// ==== hdl/decode_if.sv ====
`include "ctrl_defs.svh"
`default_nettype none

interface decode_if;
	import ctrl_pkg::*;

	instr_class_e cls;
	alu_op_e arith_op;
	shift_op_e shift_op;
	logic variant; // bne, ble or addiu.
	logic [`CTRL_STORE_W-1:0] store_size;

	modport decoder (
		output cls, arith_op, shift_op, variant, store_size
	);

	modport consumer (
		input cls, arith_op, shift_op, variant, store_size
	);
endinterface

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`include "ctrl_defs.svh"
`default_nettype none

module instr_decoder (
	input wire logic [`CTRL_OPCODE_W-1:0] i_op_code,
	input wire logic [`CTRL_OPCODE_W-1:0] i_funct,
	decode_if.decoder dec
);
	import ctrl_pkg::*;

	always_comb begin
		dec.cls = CLS_UNKNOWN;
		dec.arith_op = ALU_ADD;
		dec.shift_op = SHIFT_LEFT;
		dec.variant = 1'b0;
		dec.store_size = `STORE_WORD;

		case (i_op_code)
			OP_RTYPE: begin
				case (i_funct)
					FN_ADD: dec.cls = CLS_ARITH;
					FN_SUB: begin
						dec.cls = CLS_ARITH;
						dec.arith_op = ALU_SUB;
					end
					FN_AND: begin
						dec.cls = CLS_ARITH;
						dec.arith_op = ALU_AND;
					end
					FN_SLL: dec.cls = CLS_SHIFT_IMM;
					FN_SRL: begin
						dec.cls = CLS_SHIFT_IMM;
						dec.shift_op = SHIFT_RIGHT_LOG;
					end
					FN_SRA: begin
						dec.cls = CLS_SHIFT_IMM;
						dec.shift_op = SHIFT_RIGHT_ARITH;
					end
					FN_SLLV: dec.cls = CLS_SHIFT_REG;
					FN_SRAV: begin
						dec.cls = CLS_SHIFT_REG;
						dec.shift_op = SHIFT_RIGHT_ARITH;
					end
					FN_SLT: dec.cls = CLS_SLT;
					FN_JR: dec.cls = CLS_JR;
					FN_BREAK: dec.cls = CLS_BREAK;
					FN_RTE: dec.cls = CLS_RTE;
					default: dec.cls = CLS_UNKNOWN; // falls through to close.
				endcase
			end
			OP_ADDI: dec.cls = CLS_ADD_IMM;
			OP_ADDIU: begin
				dec.cls = CLS_ADD_IMM;
				dec.variant = 1'b1;
			end
			OP_BEQ: dec.cls = CLS_BRANCH_EQ;
			OP_BNE: begin
				dec.cls = CLS_BRANCH_EQ;
				dec.variant = 1'b1;
			end
			OP_BGT: dec.cls = CLS_BRANCH_CMP;
			OP_BLE: begin
				dec.cls = CLS_BRANCH_CMP;
				dec.variant = 1'b1;
			end
			OP_SW: dec.cls = CLS_STORE;
			OP_SH: begin
				dec.cls = CLS_STORE;
				dec.store_size = `STORE_HALF;
			end
			OP_SB: begin
				dec.cls = CLS_STORE;
				dec.store_size = `STORE_BYTE;
			end
			OP_J: dec.cls = CLS_JUMP;
			OP_JAL: dec.cls = CLS_JAL;
			default: dec.cls = CLS_UNKNOWN;
		endcase
	end
endmodule

`default_nettype wire

// ==== hdl/ctrl_sequencer.sv ====
`include "ctrl_defs.svh"
`default_nettype none

module ctrl_sequencer (
	input wire logic i_clock,
	input wire logic i_reset,
	decode_if.consumer dec,
	output ctrl_pkg::ctrl_state_e o_state
);
	import ctrl_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_next;
	ctrl_state_e shift_target;
	ctrl_state_e arith_target;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_FETCH_1;
		end else begin
			state <= state_next;
		end
	end

	assign o_state = state;

	// both shift entry states land on the same operation states.
	always_comb begin
		case (dec.shift_op)
			SHIFT_RIGHT_LOG: shift_target = ST_SHIFT_RIGHT_LOG;
			SHIFT_RIGHT_ARITH: shift_target = ST_SHIFT_RIGHT_ARITH;
			default: shift_target = ST_SHIFT_LEFT;
		endcase
	end

	always_comb begin
		case (dec.arith_op)
			ALU_SUB: arith_target = ST_SUB;
			ALU_AND: arith_target = ST_AND;
			default: arith_target = ST_ADD;
		endcase
	end

	// ~~~~~~~~~~~~~~~ next state ~~~~~~~~~~~~~~~
	always_comb begin
		case (state)
			ST_FETCH_1: state_next = ST_FETCH_2;
			ST_FETCH_2: state_next = ST_FETCH_3;
			ST_FETCH_3: state_next = ST_DECODE_1;
			ST_DECODE_1: state_next = ST_DECODE_2;
			ST_DECODE_2: begin
				case (dec.cls)
					CLS_ARITH: state_next = arith_target;
					CLS_SHIFT_IMM: state_next = ST_SHIFT_SHAMT;
					CLS_SHIFT_REG: state_next = ST_SHIFT_REG;
					CLS_SLT: state_next = ST_SLT;
					CLS_ADD_IMM: state_next = ST_ADD_IMM;
					CLS_BRANCH_EQ: state_next = ST_BRANCH_EQ_1;
					CLS_BRANCH_CMP: state_next = ST_BRANCH_CMP_1;
					CLS_STORE: state_next = ST_STORE_1;
					CLS_BREAK: state_next = ST_BREAK;
					CLS_JR: state_next = ST_JR;
					CLS_RTE: state_next = ST_RTE;
					CLS_JUMP: state_next = ST_J;
					CLS_JAL: state_next = ST_JAL_1;
					default: state_next = ST_CLOSE; // unknown instruction.
				endcase
			end
			ST_ADD, ST_SUB, ST_AND: state_next = ST_ARITH_WB;
			ST_SHIFT_SHAMT, ST_SHIFT_REG: state_next = shift_target;
			ST_SHIFT_LEFT, ST_SHIFT_RIGHT_ARITH, ST_SHIFT_RIGHT_LOG: state_next = ST_SHIFT_WB;
			ST_ADD_IMM: state_next = ST_ADD_IMM_WB;
			ST_BRANCH_EQ_1: state_next = ST_BRANCH_EQ_2;
			ST_BRANCH_CMP_1: state_next = ST_BRANCH_CMP_2;
			ST_STORE_1: state_next = ST_STORE_2;
			ST_STORE_2: state_next = ST_STORE_3;
			ST_STORE_3: begin
				case (dec.store_size)
					`STORE_HALF: state_next = ST_SH;
					`STORE_BYTE: state_next = ST_SB;
					default: state_next = ST_SW;
				endcase
			end
			ST_JAL_1: state_next = ST_JAL_2;
			ST_JAL_2: state_next = ST_JAL_3;
			ST_CLOSE: state_next = ST_FETCH_1;
			// single cycle paths and write-back steps all end in close.
			ST_ARITH_WB, ST_SHIFT_WB, ST_SLT, ST_ADD_IMM_WB, ST_BRANCH_EQ_2,
			ST_BRANCH_CMP_2, ST_SW, ST_SH, ST_SB, ST_BREAK, ST_JR, ST_RTE, ST_J,
			ST_JAL_3: state_next = ST_CLOSE;
			default: state_next = ST_FETCH_1;
		endcase
	end
endmodule

`default_nettype wire

// ==== hdl/ctrl_signal_gen.sv ====
`include "ctrl_defs.svh"
`default_nettype none

module ctrl_signal_gen (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire ctrl_pkg::ctrl_state_e i_state,
	decode_if.consumer dec,
	input wire logic i_equal,
	input wire logic i_greater,
	output logic o_ir_write,
	output logic o_pc_write,
	output logic o_memory_write,
	output logic o_reg_write,
	output logic o_a_b_write,
	output logic o_mem_data_write,
	output logic o_alu_out_write,
	output logic o_alu_src_a,
	output logic o_shift_src_control,
	output logic [`CTRL_IORD_W-1:0] o_i_or_d,
	output logic [`CTRL_PCSRC_W-1:0] o_pc_source,
	output logic [`CTRL_SRCB_W-1:0] o_alu_src_b,
	output logic [`CTRL_REGDST_W-1:0] o_reg_dst,
	output logic [`CTRL_STORE_W-1:0] o_store_size,
	output logic [1:0] o_shift_amount_control,
	output ctrl_pkg::alu_op_e o_alu_op,
	output ctrl_pkg::shift_op_e o_shift_control,
	output logic [`CTRL_MEMTOREG_W-1:0] o_mem_to_reg
);
	import ctrl_pkg::*;

	always_ff @(posedge i_clock) begin
		// every line idles low unless the state below names it.
		o_ir_write <= 1'b0;
		o_pc_write <= 1'b0;
		o_memory_write <= 1'b0;
		o_reg_write <= 1'b0;
		o_a_b_write <= 1'b0;
		o_mem_data_write <= 1'b0;
		o_alu_out_write <= 1'b0;
		o_alu_src_a <= 1'b0;
		o_shift_src_control <= 1'b0;
		o_i_or_d <= '0;
		o_pc_source <= `PC_SRC_ALU;
		o_alu_src_b <= `SRCB_B;
		o_reg_dst <= `REG_DST_RT;
		o_store_size <= '0;
		o_shift_amount_control <= 2'b00;
		o_alu_op <= ALU_LOAD;
		o_shift_control <= SHIFT_NONE;
		o_mem_to_reg <= `WB_ALUOUT;

		if (!i_reset) begin
			case (i_state)
				// ~~~~~~~~~~~~~~~ fetch and decode ~~~~~~~~~~~~~~~
				ST_FETCH_1, ST_FETCH_2, ST_FETCH_3: begin
					o_alu_op <= ALU_ADD; // pc + 4.
					o_alu_src_b <= `SRCB_FOUR;
					o_pc_write <= (i_state == ST_FETCH_2);
					o_ir_write <= (i_state == ST_FETCH_3);
				end
				ST_DECODE_1: begin
					o_alu_op <= ALU_ADD; // branch target into aluout.
					o_alu_src_b <= `SRCB_BRANCH_OFS;
					o_a_b_write <= 1'b1;
					o_alu_out_write <= 1'b1;
				end
				ST_DECODE_2: o_alu_op <= ALU_ADD;

				// ~~~~~~~~~~~~~~~ execute ~~~~~~~~~~~~~~~
				ST_ADD, ST_SUB, ST_AND: begin
					o_alu_op <= (i_state == ST_SUB) ? ALU_SUB :
						(i_state == ST_AND) ? ALU_AND : ALU_ADD;
					o_alu_src_a <= 1'b1;
					o_alu_out_write <= 1'b1;
				end
				ST_ARITH_WB, ST_SHIFT_WB: begin
					o_reg_write <= 1'b1;
					o_reg_dst <= `REG_DST_RD;
					o_mem_to_reg <= (i_state == ST_SHIFT_WB) ? `WB_SHIFT : `WB_ALUOUT;
				end
				ST_SHIFT_SHAMT: begin
					o_shift_control <= SHIFT_LOAD;
					o_shift_src_control <= 1'b1;
					o_shift_amount_control <= 2'b10; // shamt field.
				end
				ST_SHIFT_REG: o_shift_control <= SHIFT_LOAD;
				ST_SHIFT_LEFT: o_shift_control <= SHIFT_LEFT;
				ST_SHIFT_RIGHT_LOG: o_shift_control <= SHIFT_RIGHT_LOG;
				ST_SHIFT_RIGHT_ARITH: o_shift_control <= SHIFT_RIGHT_ARITH;
				ST_SLT: begin
					o_alu_op <= ALU_CMP;
					o_alu_src_a <= 1'b1;
					o_reg_write <= 1'b1;
					o_reg_dst <= `REG_DST_RD;
					o_mem_to_reg <= `WB_SLT;
				end
				ST_ADD_IMM: begin
					o_alu_op <= ALU_ADD;
					o_alu_src_a <= 1'b1;
					o_alu_src_b <= `SRCB_IMM;
					o_alu_out_write <= 1'b1;
				end
				ST_ADD_IMM_WB: begin
					o_reg_write <= 1'b1;
					if (!dec.variant) begin
						o_alu_op <= ALU_ADD; // addi keeps the overflow flag live.
						o_alu_src_a <= 1'b1;
						o_alu_src_b <= `SRCB_IMM;
					end
				end

				// ~~~~~~~~~~~~~~~ branches ~~~~~~~~~~~~~~~
				ST_BRANCH_EQ_1, ST_BRANCH_CMP_1: begin
					o_alu_op <= ALU_CMP;
					o_alu_src_a <= 1'b1;
					o_pc_source <= `PC_SRC_BRANCH;
				end
				ST_BRANCH_EQ_2: begin
					o_alu_op <= ALU_CMP;
					o_alu_src_a <= 1'b1;
					o_pc_source <= `PC_SRC_BRANCH;
					o_pc_write <= dec.variant ? !i_equal : i_equal; // bne : beq.
				end
				ST_BRANCH_CMP_2: begin
					o_alu_op <= ALU_CMP;
					o_alu_src_a <= 1'b1;
					o_pc_source <= `PC_SRC_BRANCH;
					o_pc_write <= dec.variant ? !i_greater : i_greater; // ble : bgt.
				end

				// ~~~~~~~~~~~~~~~ stores ~~~~~~~~~~~~~~~
				ST_STORE_1, ST_STORE_2, ST_STORE_3: begin
					o_alu_op <= ALU_ADD; // base + offset.
					o_alu_src_a <= 1'b1;
					o_alu_src_b <= `SRCB_IMM;
					o_i_or_d <= 2'b01;
					o_alu_out_write <= (i_state == ST_STORE_1);
					o_mem_data_write <= (i_state == ST_STORE_3);
				end
				ST_SW, ST_SH, ST_SB: begin
					o_memory_write <= 1'b1;
					o_i_or_d <= 2'b01;
					o_store_size <= (i_state == ST_SH) ? `STORE_HALF :
						(i_state == ST_SB) ? `STORE_BYTE : `STORE_WORD;
				end

				// ~~~~~~~~~~~~~~~ jumps ~~~~~~~~~~~~~~~
				ST_BREAK: begin
					o_pc_write <= 1'b1;
					o_alu_op <= ALU_SUB; // back to the break itself.
					o_alu_src_b <= `SRCB_FOUR;
				end
				ST_JR: begin
					o_pc_write <= 1'b1;
					o_alu_src_a <= 1'b1;
				end
				ST_RTE: begin
					o_pc_write <= 1'b1;
					o_pc_source <= `PC_SRC_EPC;
				end
				ST_J, ST_JAL_3: begin
					o_pc_write <= 1'b1;
					o_pc_source <= `PC_SRC_JUMP;
				end
				ST_JAL_1: o_alu_out_write <= 1'b1; // return address.
				ST_JAL_2: begin
					o_reg_write <= 1'b1;
					o_reg_dst <= `REG_DST_RA;
				end
				default: ; // close keeps everything idle.
			endcase
		end
	end
endmodule

`default_nettype wire

// ==== hdl/ctrl_unit.sv ====
`include "ctrl_defs.svh"
`default_nettype none

module ctrl_unit (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic [`CTRL_OPCODE_W-1:0] i_op_code,
	input wire logic [`CTRL_OPCODE_W-1:0] i_funct,
	input wire logic i_equal,
	input wire logic i_greater,
	output logic o_ir_write,
	output logic o_pc_write,
	output logic o_memory_write,
	output logic o_reg_write,
	output logic o_a_b_write,
	output logic o_mem_data_write,
	output logic o_alu_out_write,
	output logic o_alu_src_a,
	output logic o_shift_src_control,
	output logic [`CTRL_IORD_W-1:0] o_i_or_d,
	output logic [`CTRL_PCSRC_W-1:0] o_pc_source,
	output logic [`CTRL_SRCB_W-1:0] o_alu_src_b,
	output logic [`CTRL_REGDST_W-1:0] o_reg_dst,
	output logic [`CTRL_STORE_W-1:0] o_store_size,
	output logic [1:0] o_shift_amount_control,
	output ctrl_pkg::alu_op_e o_alu_op,
	output ctrl_pkg::shift_op_e o_shift_control,
	output logic [`CTRL_MEMTOREG_W-1:0] o_mem_to_reg
);
	import ctrl_pkg::*;

	ctrl_state_e state;

	decode_if dec ();

	instr_decoder u_decoder (
		.i_op_code(i_op_code),
		.i_funct(i_funct),
		.dec(dec)
	);

	ctrl_sequencer u_sequencer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.dec(dec),
		.o_state(state)
	);

	// outputs share names with the generator ports.
	ctrl_signal_gen u_signal_gen (
		.i_state(state),
		.*
	);
endmodule

`default_nettype wire

// ==== verification/ctrl_unit_sva.sv ====
`default_nettype none

module ctrl_unit_sva (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_ir_write,
	input wire logic i_memory_write,
	input wire logic i_reg_write,
	input wire logic [29:0] i_all_outputs
);
	timeunit 1ns;
	timeprecision 100ps;

	// only fetch step three raises ir_write.
	ir_write_single: assert property (@(posedge i_clock) disable iff (i_reset)
		i_ir_write |=> !i_ir_write)
		else $error("o_ir_write stayed high for two cycles");

	store_or_write_back: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_memory_write && i_reg_write))
		else $error("o_memory_write and o_reg_write high in the same cycle");

	idle_after_reset: assert property (@(posedge i_clock)
		i_reset |=> (i_all_outputs == '0))
		else $error("control outputs not idle in the cycle after reset");
endmodule

bind ctrl_unit ctrl_unit_sva u_sva (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_ir_write(o_ir_write),
	.i_memory_write(o_memory_write),
	.i_reg_write(o_reg_write),
	.i_all_outputs({o_ir_write, o_pc_write, o_memory_write, o_reg_write, o_a_b_write,
		o_mem_data_write, o_alu_out_write, o_alu_src_a, o_shift_src_control, o_i_or_d,
		o_pc_source, o_alu_src_b, o_reg_dst, o_store_size, o_shift_amount_control,
		o_alu_op, o_shift_control, o_mem_to_reg})
);

`default_nettype wire

// ==== verification/ctrl_checker.sv ====
`default_nettype none

module ctrl_checker (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic [29:0] i_all_outputs,
	input wire logic i_ir_write,
	input wire logic i_pc_write,
	input wire logic i_memory_write,
	input wire logic i_reg_write,
	input wire logic [1:0] i_pc_source,
	input wire logic [1:0] i_reg_dst,
	input wire logic [1:0] i_store_size,
	input wire logic [2:0] i_mem_to_reg,
	input wire ctrl_pkg::alu_op_e i_alu_op,
	input wire ctrl_pkg::shift_op_e i_shift_control,
	input wire logic [63:0] i_exp_name,
	input var int i_exp_len,
	input var int i_exp_reg_writes,
	input wire logic [2:0] i_exp_wb,
	input wire logic [1:0] i_exp_dst,
	input wire logic [2:0] i_exp_alu,
	input wire logic [2:0] i_exp_shift,
	input var int i_exp_mem_writes,
	input wire logic [1:0] i_exp_size,
	input var int i_exp_pc_writes,
	input wire logic [1:0] i_exp_pc_source,
	output int o_tests,
	output int o_errors
);
	timeunit 1ns;
	timeprecision 100ps;
	import ctrl_pkg::*;

	int tests = 0;
	int errors = 0;
	logic reset_q = 1'b1;
	logic started = 1'b0;
	int since_reset = 0;

	// expected values of the instruction in flight.
	logic [63:0] want_name;
	int want_len;
	int want_reg_writes;
	logic [2:0] want_wb;
	logic [1:0] want_dst;
	logic [2:0] want_alu;
	logic [2:0] want_shift;
	int want_mem_writes;
	logic [1:0] want_size;
	int want_pc_writes;
	logic [1:0] want_pc_source;

	// what the DUT did so far in this window.
	int offset;
	int reg_writes;
	int mem_writes;
	int pc_writes;
	logic [2:0] seen_wb;
	logic [1:0] seen_dst;
	logic [1:0] seen_size;
	logic [1:0] seen_pc_source;
	logic alu_hit;
	logic shift_hit;

	assign o_tests = tests;
	assign o_errors = errors;

	task automatic check_value(input string signal, input int got, input int want);
		if (got != want) begin
			$display("FAILED t=%0t %s got %0d expected %0d", $time, signal, got, want);
			errors++;
		end
	endtask

	task automatic start_window();
		want_name = i_exp_name;
		want_len = i_exp_len;
		want_reg_writes = i_exp_reg_writes;
		want_wb = i_exp_wb;
		want_dst = i_exp_dst;
		want_alu = i_exp_alu;
		want_shift = i_exp_shift;
		want_mem_writes = i_exp_mem_writes;
		want_size = i_exp_size;
		want_pc_writes = i_exp_pc_writes;
		want_pc_source = i_exp_pc_source;
		offset = 0;
		reg_writes = 0;
		mem_writes = 0;
		pc_writes = 0;
		seen_wb = '0;
		seen_dst = '0;
		seen_size = '0;
		seen_pc_source = '0;
		alu_hit = 1'b0;
		shift_hit = 1'b0;
	endtask

	task automatic observe_cycle();
		if (i_reg_write) begin
			reg_writes++;
			seen_wb = i_mem_to_reg;
			seen_dst = i_reg_dst;
		end
		if (i_memory_write) begin
			mem_writes++;
			seen_size = i_store_size;
		end
		if (i_pc_write) begin
			if (pc_writes == 0) seen_pc_source = i_pc_source; // the jump comes before fetch.
			pc_writes++;
		end
		// execute sits between decode step two and close.
		if (offset >= 3 && offset <= want_len - 4) begin
			alu_hit = alu_hit | (i_alu_op == want_alu);
			shift_hit = shift_hit | (i_shift_control == want_shift);
		end
		offset++;
	endtask

	task automatic finish_window();
		int errors_before;
		errors_before = errors;
		tests++;
		check_value("instruction cycles", offset, want_len);
		check_value("o_reg_write cycles", reg_writes, want_reg_writes);
		if (want_reg_writes > 0) begin
			check_value("o_mem_to_reg", int'(seen_wb), int'(want_wb));
			check_value("o_reg_dst", int'(seen_dst), int'(want_dst));
		end
		check_value("o_memory_write cycles", mem_writes, want_mem_writes);
		if (want_mem_writes > 0) check_value("o_store_size", int'(seen_size), int'(want_size));
		check_value("o_pc_write jump cycles", pc_writes - 1, want_pc_writes); // minus fetch.
		if (want_pc_writes > 0) begin
			check_value("o_pc_source", int'(seen_pc_source), int'(want_pc_source));
		end
		if (want_alu != ALU_LOAD && !alu_hit) begin
			$display("t=%0t o_alu_op never showed code %0d during execute", $time, want_alu);
			errors++;
		end
		if (want_shift != SHIFT_NONE && !shift_hit) begin
			$display("t=%0t o_shift_control never showed code %0d during execute",
				$time, want_shift);
			errors++;
		end
		if (errors == errors_before) begin
			$display("test %0d %0s: ok", tests, want_name);
		end else begin
			$display("test %0d %0s: %0d mismatches", tests, want_name, errors - errors_before);
		end
	endtask

	always @(posedge i_clock) reset_q <= i_reset;

	// ~~~~~~~~~~~ sampled mid cycle ~~~~~~~~~~~
	always @(negedge i_clock) begin
		if (reset_q) begin
			if (i_all_outputs != '0) begin
				$display("FAILED t=%0t control outputs got %h expected 0", $time, i_all_outputs);
				errors++;
			end
		end else if (!started) begin
			since_reset++;
			if (i_ir_write) begin
				started = 1'b1;
				tests++;
				check_value("first o_ir_write cycle", since_reset, 3);
				if (errors == 0) begin
					$display("test %0d reset: ok", tests);
				end else begin
					$display("test %0d reset: %0d mismatches", tests, errors);
				end
				start_window();
				observe_cycle();
			end
		end else begin
			if (i_ir_write) begin
				finish_window();
				start_window();
			end
			observe_cycle();
		end
	end
endmodule

`default_nettype wire

// ==== verification/ctrl_unit_tb.sv ====
`include "ctrl_defs.svh"
`default_nettype none

module ctrl_unit_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import ctrl_pkg::*;

	localparam string TRACE_FILE = "verification/ctrl_trace.txt";

	logic clock = 1'b0;
	logic reset;
	logic [`CTRL_OPCODE_W-1:0] op_code;
	logic [`CTRL_OPCODE_W-1:0] funct;
	logic equal;
	logic greater;

	logic ir_write;
	logic pc_write;
	logic memory_write;
	logic reg_write;
	logic a_b_write;
	logic mem_data_write;
	logic alu_out_write;
	logic alu_src_a;
	logic shift_src_control;
	logic [`CTRL_IORD_W-1:0] i_or_d;
	logic [`CTRL_PCSRC_W-1:0] pc_source;
	logic [`CTRL_SRCB_W-1:0] alu_src_b;
	logic [`CTRL_REGDST_W-1:0] reg_dst;
	logic [`CTRL_STORE_W-1:0] store_size;
	logic [1:0] shift_amount_control;
	alu_op_e alu_op;
	shift_op_e shift_control;
	logic [`CTRL_MEMTOREG_W-1:0] mem_to_reg;
	logic [29:0] all_outputs;

	logic [63:0] exp_name;
	int exp_len;
	int exp_reg_writes;
	logic [2:0] exp_wb;
	logic [1:0] exp_dst;
	logic [2:0] exp_alu;
	logic [2:0] exp_shift;
	int exp_mem_writes;
	logic [1:0] exp_size;
	int exp_pc_writes;
	logic [1:0] exp_pc_source;

	string trace_lines[$];
	int bad_lines = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int tests;
	int errors;

	always #5 clock = ~clock;

	assign all_outputs = {ir_write, pc_write, memory_write, reg_write, a_b_write,
		mem_data_write, alu_out_write, alu_src_a, shift_src_control, i_or_d, pc_source,
		alu_src_b, reg_dst, store_size, shift_amount_control, alu_op, shift_control,
		mem_to_reg};

	ctrl_unit UUT (
		.i_clock(clock),
		.i_reset(reset),
		.i_op_code(op_code),
		.i_funct(funct),
		.i_equal(equal),
		.i_greater(greater),
		.o_ir_write(ir_write),
		.o_pc_write(pc_write),
		.o_memory_write(memory_write),
		.o_reg_write(reg_write),
		.o_a_b_write(a_b_write),
		.o_mem_data_write(mem_data_write),
		.o_alu_out_write(alu_out_write),
		.o_alu_src_a(alu_src_a),
		.o_shift_src_control(shift_src_control),
		.o_i_or_d(i_or_d),
		.o_pc_source(pc_source),
		.o_alu_src_b(alu_src_b),
		.o_reg_dst(reg_dst),
		.o_store_size(store_size),
		.o_shift_amount_control(shift_amount_control),
		.o_alu_op(alu_op),
		.o_shift_control(shift_control),
		.o_mem_to_reg(mem_to_reg)
	);

	ctrl_checker u_checker (
		.i_clock(clock),
		.i_reset(reset),
		.i_all_outputs(all_outputs),
		.i_ir_write(ir_write),
		.i_pc_write(pc_write),
		.i_memory_write(memory_write),
		.i_reg_write(reg_write),
		.i_pc_source(pc_source),
		.i_reg_dst(reg_dst),
		.i_store_size(store_size),
		.i_mem_to_reg(mem_to_reg),
		.i_alu_op(alu_op),
		.i_shift_control(shift_control),
		.i_exp_name(exp_name),
		.i_exp_len(exp_len),
		.i_exp_reg_writes(exp_reg_writes),
		.i_exp_wb(exp_wb),
		.i_exp_dst(exp_dst),
		.i_exp_alu(exp_alu),
		.i_exp_shift(exp_shift),
		.i_exp_mem_writes(exp_mem_writes),
		.i_exp_size(exp_size),
		.i_exp_pc_writes(exp_pc_writes),
		.i_exp_pc_source(exp_pc_source),
		.o_tests(tests),
		.o_errors(errors)
	);

	task automatic load_trace();
		int fd;
		string text;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the trace file %s", TRACE_FILE);
		end else begin
			while (!$feof(fd)) begin
				text = "";
				void'($fgets(text, fd));
				if (text.len() > 1 && text.getc(0) != "#") trace_lines.push_back(text);
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_line(input string text);
		int fields;
		fields = $sscanf(text, "%s %h %h %b %b %d %d %d %d %d %d %d %d %d %d", exp_name,
			op_code, funct, equal, greater, exp_len, exp_reg_writes, exp_wb, exp_dst,
			exp_alu, exp_shift, exp_mem_writes, exp_size, exp_pc_writes, exp_pc_source);
		if (fields != 15) begin
			$display("trace line has %0d fields instead of 15: %s", fields, text);
			bad_lines++;
		end
	endtask

	// returns 1 ns after the edge that raised ir_write.
	task automatic wait_for_fetch();
		do begin
			@(posedge clock);
			#1;
		end while (!ir_write);
	endtask

	// ~~~~~~~~~~~ timeout ~~~~~~~~~~~
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("run stopped after %0d cycles with the trace unfinished", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		op_code = '0;
		funct = '0;
		equal = 1'b0;
		greater = 1'b0;
		exp_name = '0;
		exp_len = 0;
		exp_reg_writes = 0;
		exp_wb = '0;
		exp_dst = '0;
		exp_alu = '0;
		exp_shift = '0;
		exp_mem_writes = 0;
		exp_size = '0;
		exp_pc_writes = 0;
		exp_pc_source = '0;
		load_trace();
		cycle_limit = trace_lines.size() * 10 + 20;
		if (trace_lines.size() == 0) begin
			$display("no instructions could be read from %s", TRACE_FILE);
			$display("Simulation FAILED");
			$finish;
		end else begin
			repeat (3) @(posedge clock);
			#1 reset = 1'b0;
			foreach (trace_lines[idx]) begin
				wait_for_fetch();
				apply_line(trace_lines[idx]);
			end
			wait_for_fetch(); // closes the window of the last line.
			repeat (2) @(posedge clock);
			$display("%0d tests run, %0d errors", tests, errors + bad_lines);
			if (errors == 0 && bad_lines == 0 && tests == trace_lines.size() + 1) begin
				$display("Simulation PASSED");
			end else begin
				$display("Simulation FAILED");
			end
			$finish;
		end
	end
endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hdl
hdl/ctrl_pkg.sv
hdl/decode_if.sv
hdl/instr_decoder.sv
hdl/ctrl_sequencer.sv
hdl/ctrl_signal_gen.sv
hdl/ctrl_unit.sv
verification/ctrl_unit_sva.sv
verification/ctrl_checker.sv
verification/ctrl_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ctrl_unit_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "fail message found in $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/ctrl_trace.txt ====
# name opcode funct equal greater cycles reg_write wb_sel reg_dst alu_op shift_op
# mem_write store_size pc_jumps pc_source (opcode and funct hex, the rest decimal)
add    00 20 0 0  8 1 0 3 1 0 0 0 0 0
sub    00 22 1 0  8 1 0 3 2 0 0 0 0 0
and    00 24 0 1  8 1 0 3 3 0 0 0 0 0
slt    00 2a 0 0  7 1 4 3 7 0 0 0 0 0
sll    00 00 0 0  9 1 5 3 0 2 0 0 0 0
srl    00 02 1 1  9 1 5 3 0 3 0 0 0 0
sra    00 03 0 0  9 1 5 3 0 4 0 0 0 0
sllv   00 04 0 0  9 1 5 3 0 2 0 0 0 0
srav   00 07 0 1  9 1 5 3 0 4 0 0 0 0
addi   08 00 0 0  8 1 0 0 1 0 0 0 0 0
addiu  09 00 1 0  8 1 0 0 1 0 0 0 0 0
beq_t  04 00 1 0  8 0 0 0 7 0 0 0 1 1
beq_n  04 00 0 1  8 0 0 0 7 0 0 0 0 0
bne_t  05 00 0 0  8 0 0 0 7 0 0 0 1 1
bne_n  05 00 1 1  8 0 0 0 7 0 0 0 0 0
bgt_t  07 00 0 1  8 0 0 0 7 0 0 0 1 1
bgt_n  07 00 1 0  8 0 0 0 7 0 0 0 0 0
ble_t  06 00 1 0  8 0 0 0 7 0 0 0 1 1
ble_n  06 00 0 1  8 0 0 0 7 0 0 0 0 0
sw     2b 00 0 0 10 0 0 0 1 0 1 1 0 0
sh     29 00 0 0 10 0 0 0 1 0 1 2 0 0
sb     28 00 0 0 10 0 0 0 1 0 1 3 0 0
jr     00 08 0 0  7 0 0 0 0 0 0 0 1 0
break  00 0d 0 0  7 0 0 0 0 0 0 0 1 0
rte    00 13 0 0  7 0 0 0 0 0 0 0 1 3
j      02 00 0 0  7 0 0 0 0 0 0 0 1 2
jal    03 00 0 0  9 1 0 1 0 0 0 0 1 2
lw     23 00 0 0  6 0 0 0 0 0 0 0 0 0
mult   00 18 0 0  6 0 0 0 0 0 0 0 0 0
